// ==== Bender.yml ====
package:
  name: mac_accel

sources:
  - include_dirs:
      - source
    files:
      - source/mac_ctrl_pkg.sv
      - source/mac_data_pkg.sv
      - source/mac_periph_decode.sv
      - source/mac_ctrl.sv
      - source/mac_engine.sv
      - source/mac_result.sv
      - source/mac_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_mac_top.sv

// ==== source/mac_cfg.svh ====
// Widths are fixed at elaboration and MAC_K_W must be wide enough to hold MAC_MAX_K
`ifndef MAC_CFG_SVH
`define MAC_CFG_SVH

// Operand pair and datapath widths
`define MAC_OP_W   16
`define MAC_ACC_W  40
`define MAC_RES_W  32

// Job length limits
`define MAC_MAX_K  255
`define MAC_K_W    8

// Register port address width
`define MAC_ADDR_W 8

`endif

// ==== source/mac_ctrl.sv ====
// Single job at a time; a start request without a valid configuration keeps the FSM idle
`default_nettype none

module mac_ctrl (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        soft_clear_i,
  input  wire mac_ctrl_pkg::reg_file_t     reg_file_i,
  input  wire logic                        cfg_valid_i,
  input  wire logic                        start_req_i,
  input  wire mac_ctrl_pkg::engine_flags_t engine_flags_i,
  output mac_ctrl_pkg::engine_ctrl_t       engine_ctrl_o,
  output logic                             start_ack_o,
  output logic                             capture_o,
  output logic                             clear_o,
  output logic                             busy_o,
  output logic                             evt_o
);

  import mac_ctrl_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Clear covers the soft clear and the first cycle out of reset
  assign clear_o = soft_clear_i || (state_q == CTRL_LATCH_RST);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_LATCH_RST;
    end else if (clear_o) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_LATCH_RST: begin
        state_d = CTRL_IDLE;
      end
      CTRL_IDLE: begin
        if (start_req_i && cfg_valid_i) begin
          state_d = CTRL_STARTING;
        end
      end
      // First cycle loads, second cycle sees primed
      CTRL_STARTING: begin
        if (engine_flags_i.primed) begin
          state_d = CTRL_COMPUTING;
        end
      end
      CTRL_COMPUTING: begin
        if (engine_flags_i.done) begin
          state_d = CTRL_FINISHED;
        end
      end
      CTRL_FINISHED: begin
        state_d = CTRL_IDLE;
      end
      default: begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  assign start_ack_o   = (state_q == CTRL_IDLE) && (state_d == CTRL_STARTING);
  assign engine_ctrl_o = '{
    first_load: (state_q == CTRL_STARTING) && !engine_flags_i.primed,
    enable:     (state_q == CTRL_COMPUTING)
  };
  assign busy_o    = (state_q == CTRL_STARTING) || (state_q == CTRL_COMPUTING);
  assign capture_o = (state_q == CTRL_FINISHED);
  assign evt_o     = (state_q == CTRL_FINISHED);

  // An event only closes a job that ran to completion
  a_evt_after_compute: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_o |-> (state_q == CTRL_FINISHED) && ($past(state_q) == CTRL_COMPUTING));

  // Decode must keep the job configuration steady during a job
  a_cfg_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_o && $past(busy_o) |-> $stable(reg_file_i));

endmodule

`default_nettype wire

// ==== source/mac_ctrl_pkg.sv ====
// Register port carries one 32-bit word per access with no byte enables and no IDs
`default_nettype none

`include "mac_cfg.svh"

package mac_ctrl_pkg;

  // Byte addresses of the register map
  typedef enum logic [`MAC_ADDR_W-1:0] {
    REG_TRIGGER = 'h00,
    REG_STATUS  = 'h04,
    REG_K_LEN   = 'h08,
    REG_SHIFT   = 'h0C,
    REG_RESULT  = 'h10,
    REG_CLEAR   = 'h14
  } reg_addr_e;

  // Host request, wen high means write
  typedef struct packed {
    logic                   req;
    logic                   wen;
    logic [`MAC_ADDR_W-1:0] add;
    logic [31:0]            data;
  } periph_req_t;

  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_data;
  } periph_rsp_t;

  typedef struct packed {
    logic [`MAC_K_W-1:0] k_len;
    logic [4:0]          shift;
  } reg_file_t;

  typedef enum logic [2:0] {
    CTRL_LATCH_RST,
    CTRL_IDLE,
    CTRL_STARTING,
    CTRL_COMPUTING,
    CTRL_FINISHED
  } ctrl_state_e;

  // Orders from the controller to the engine
  typedef struct packed {
    logic first_load;
    logic enable;
  } engine_ctrl_t;

  // Engine progress reports
  typedef struct packed {
    logic primed;
    logic done;
  } engine_flags_t;

endpackage

`default_nettype wire

// ==== source/mac_data_pkg.sv ====
// Operands are two's complement and the accumulator must absorb MAC_MAX_K full-scale products
`default_nettype none

`include "mac_cfg.svh"

package mac_data_pkg;

  // One operand pair from the input stream
  typedef struct packed {
    logic signed [`MAC_OP_W-1:0] x;
    logic signed [`MAC_OP_W-1:0] w;
  } operand_t;

  typedef logic signed [2*`MAC_OP_W-1:0] product_t;

  typedef logic signed [`MAC_ACC_W-1:0] accum_t;

  // Final value after shift and clamp
  typedef struct packed {
    logic [`MAC_RES_W-1:0] value;
    logic                  saturated;
  } result_t;

endpackage

`default_nettype wire

// ==== source/mac_engine.sv ====
// No back-pressure on the operand stream; pairs beyond K or outside a job are dropped
`default_nettype none

`include "mac_cfg.svh"

module mac_engine (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       clear_i,
  input  wire logic [`MAC_K_W-1:0]        k_len_i,
  input  wire mac_ctrl_pkg::engine_ctrl_t engine_ctrl_i,
  input  wire mac_data_pkg::operand_t     op_i,
  input  wire logic                       op_valid_i,
  output mac_ctrl_pkg::engine_flags_t     engine_flags_o,
  output mac_data_pkg::accum_t            sum_o
);

  import mac_data_pkg::*;

  logic [`MAC_K_W-1:0] taken_q;
  logic [`MAC_K_W-1:0] retired_q;
  logic                restart;
  logic                take;
  logic                prod_valid_q;
  logic                primed_q;
  logic                done_q;
  product_t            prod_q;
  accum_t              acc_q;

  assign restart = clear_i || engine_ctrl_i.first_load;
  assign take    = engine_ctrl_i.enable && op_valid_i && (taken_q < k_len_i);

  // Stage one
  always_ff @(posedge clk_i) begin
    if (take) begin
      prod_q <= $signed(op_i.x) * $signed(op_i.w);
    end
  end

  // Stage two
  always_ff @(posedge clk_i) begin
    if (restart) begin
      acc_q <= '0;
    end else if (prod_valid_q) begin
      acc_q <= acc_q + {{(`MAC_ACC_W-2*`MAC_OP_W){prod_q[2*`MAC_OP_W-1]}}, prod_q};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_q      <= '0;
      retired_q    <= '0;
      prod_valid_q <= 1'b0;
      primed_q     <= 1'b0;
      done_q       <= 1'b0;
    end else if (restart) begin
      taken_q      <= '0;
      retired_q    <= '0;
      prod_valid_q <= 1'b0;
      done_q       <= 1'b0;
      primed_q     <= engine_ctrl_i.first_load && !clear_i;
    end else begin
      primed_q     <= 1'b0;
      prod_valid_q <= take;
      if (take) begin
        taken_q <= taken_q + 1'b1;
      end
      if (prod_valid_q) begin
        retired_q <= retired_q + 1'b1;
      end
      // Registered so that done trails the last sum update by a cycle
      done_q <= (retired_q == k_len_i) && (k_len_i != '0);
    end
  end

  assign engine_flags_o = '{primed: primed_q, done: done_q};
  assign sum_o          = acc_q;

  a_taken_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    engine_ctrl_i.enable |-> taken_q <= k_len_i);

endmodule

`default_nettype wire

// ==== source/mac_periph_decode.sv ====
// One access per cycle with read data a cycle later; K_LEN and SHIFT writes are ignored while busy
`default_nettype none

`include "mac_cfg.svh"

module mac_periph_decode (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire mac_ctrl_pkg::periph_req_t periph_req_i,
  output mac_ctrl_pkg::periph_rsp_t      periph_rsp_o,
  input  wire logic                      busy_i,
  input  wire mac_data_pkg::result_t     result_i,
  input  wire logic                      start_ack_i,
  output mac_ctrl_pkg::reg_file_t        reg_file_o,
  output logic                           cfg_valid_o,
  output logic                           start_req_o,
  output logic                           soft_clear_o
);

  import mac_ctrl_pkg::*;

  logic        wr_en;
  logic        rd_en;
  logic        trigger_q;
  logic        soft_clear_q;
  logic        k_valid_q;
  logic        start_req_q;
  logic        cfg_err_q;
  logic        r_valid_q;
  logic [31:0] r_data_d;
  logic [31:0] r_data_q;
  reg_file_t   reg_file_q;

  assign wr_en = periph_req_i.req & periph_req_i.wen;
  assign rd_en = periph_req_i.req & ~periph_req_i.wen;

  // Job configuration, frozen while a job runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_file_q <= '0;
      k_valid_q  <= 1'b0;
    end else if (wr_en && !busy_i) begin
      if (periph_req_i.add == REG_K_LEN) begin
        reg_file_q.k_len <= periph_req_i.data[`MAC_K_W-1:0];
        // Range check on the full word so that large K is not aliased
        k_valid_q <= (periph_req_i.data != '0) && (periph_req_i.data <= `MAC_MAX_K);
      end
      if (periph_req_i.add == REG_SHIFT) begin
        reg_file_q.shift <= periph_req_i.data[4:0];
      end
    end
  end

  // Trigger and clear pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trigger_q    <= 1'b0;
      soft_clear_q <= 1'b0;
    end else begin
      trigger_q    <= wr_en && (periph_req_i.add == REG_TRIGGER);
      soft_clear_q <= wr_en && (periph_req_i.add == REG_CLEAR);
    end
  end

  // Start request held until the controller takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_req_q <= 1'b0;
      cfg_err_q   <= 1'b0;
    end else if (soft_clear_q) begin
      start_req_q <= 1'b0;
    end else begin
      if (start_ack_i) begin
        start_req_q <= 1'b0;
      end
      if (trigger_q) begin
        if (k_valid_q) begin
          start_req_q <= 1'b1;
          cfg_err_q   <= 1'b0;
        end else begin
          cfg_err_q <= 1'b1;
        end
      end
    end
  end

  // Read mux, writes answer with zero
  always_comb begin
    r_data_d = '0;
    if (rd_en) begin
      case (periph_req_i.add)
        REG_STATUS: r_data_d = {29'b0, cfg_err_q, result_i.saturated, busy_i};
        REG_K_LEN:  r_data_d = 32'(reg_file_q.k_len);
        REG_SHIFT:  r_data_d = 32'(reg_file_q.shift);
        REG_RESULT: r_data_d = result_i.value;
        default:    r_data_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= periph_req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    r_data_q <= r_data_d;
  end

  assign periph_rsp_o = '{gnt: periph_req_i.req, r_valid: r_valid_q, r_data: r_data_q};
  assign reg_file_o   = reg_file_q;
  assign cfg_valid_o  = k_valid_q;
  assign start_req_o  = start_req_q;
  assign soft_clear_o = soft_clear_q;

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_rsp_o.r_valid |-> $past(periph_rsp_o.gnt));

endmodule

`default_nettype wire

// ==== source/mac_result.sv ====
// Shift is arithmetic and the clamp targets the signed MAC_RES_W range
`default_nettype none

`include "mac_cfg.svh"

module mac_result (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 clear_i,
  input  wire logic                 capture_i,
  input  wire logic [4:0]           shift_i,
  input  wire mac_data_pkg::accum_t sum_i,
  output mac_data_pkg::result_t     result_o
);

  import mac_data_pkg::*;

  localparam accum_t res_max = {{(`MAC_ACC_W-`MAC_RES_W+1){1'b0}}, {(`MAC_RES_W-1){1'b1}}};
  localparam accum_t res_min = {{(`MAC_ACC_W-`MAC_RES_W+1){1'b1}}, {(`MAC_RES_W-1){1'b0}}};

  accum_t                shifted;
  logic [`MAC_RES_W-1:0] value_d;
  logic [`MAC_RES_W-1:0] value_q;
  logic                  sat_d;
  logic                  sat_q;

  assign shifted = sum_i >>> shift_i;

  // Clamp to the result range
  always_comb begin
    sat_d   = 1'b1;
    value_d = shifted[`MAC_RES_W-1:0];
    if (shifted > res_max) begin
      value_d = res_max[`MAC_RES_W-1:0];
    end else if (shifted < res_min) begin
      value_d = res_min[`MAC_RES_W-1:0];
    end else begin
      sat_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      value_q <= '0;
    end else if (capture_i) begin
      value_q <= value_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sat_q <= 1'b0;
    end else if (clear_i) begin
      sat_q <= 1'b0;
    end else if (capture_i) begin
      sat_q <= sat_d;
    end
  end

  assign result_o = '{value: value_q, saturated: sat_q};

endmodule

`default_nettype wire

// ==== source/mac_top.sv ====
// Single clock domain; operands must be presented with op_valid_i and are never stalled
`default_nettype none

module mac_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire mac_ctrl_pkg::periph_req_t periph_req_i,
  output mac_ctrl_pkg::periph_rsp_t      periph_rsp_o,
  input  wire mac_data_pkg::operand_t    op_i,
  input  wire logic                      op_valid_i,
  output logic                           busy_o,
  output logic                           evt_o
);

  import mac_ctrl_pkg::*;
  import mac_data_pkg::*;

  reg_file_t     reg_file;
  engine_ctrl_t  engine_ctrl;
  engine_flags_t engine_flags;
  accum_t        sum;
  result_t       result;
  logic          cfg_valid;
  logic          start_req;
  logic          start_ack;
  logic          soft_clear;
  logic          clear;
  logic          capture;

  mac_periph_decode i_decode (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .periph_req_i ( periph_req_i ),
    .periph_rsp_o ( periph_rsp_o ),
    .busy_i       ( busy_o       ),
    .result_i     ( result       ),
    .start_ack_i  ( start_ack    ),
    .reg_file_o   ( reg_file     ),
    .cfg_valid_o  ( cfg_valid    ),
    .start_req_o  ( start_req    ),
    .soft_clear_o ( soft_clear   )
  );

  mac_ctrl i_ctrl (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .soft_clear_i   ( soft_clear   ),
    .reg_file_i     ( reg_file     ),
    .cfg_valid_i    ( cfg_valid    ),
    .start_req_i    ( start_req    ),
    .engine_flags_i ( engine_flags ),
    .engine_ctrl_o  ( engine_ctrl  ),
    .start_ack_o    ( start_ack    ),
    .capture_o      ( capture      ),
    .clear_o        ( clear        ),
    .busy_o         ( busy_o       ),
    .evt_o          ( evt_o        )
  );

  mac_engine i_engine (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear          ),
    .k_len_i        ( reg_file.k_len ),
    .engine_ctrl_i  ( engine_ctrl    ),
    .op_i           ( op_i           ),
    .op_valid_i     ( op_valid_i     ),
    .engine_flags_o ( engine_flags   ),
    .sum_o          ( sum            )
  );

  mac_result i_result (
    .clk_i     ( clk_i          ),
    .rst_ni    ( rst_ni         ),
    .clear_i   ( clear          ),
    .capture_i ( capture        ),
    .shift_i   ( reg_file.shift ),
    .sum_i     ( sum            ),
    .result_o  ( result         )
  );

endmodule

`default_nettype wire

// ==== test/mac_tests.txt ====
# test name, then hex K, SHIFT, operand word x0:w0, gap mode, expected RESULT, expected STATUS
# gap mode 0 back to back, 1 idle gaps, 2 gaps with junk pairs, 3 bad K, 4 soft clear mid job
basic_shift0      08  00 00030005 0 00000104 0
neg_operands      0a  00 ffec0007 1 fffffbc3 0
shift_four        20  04 01000040 0 000087c0 0
neg_shift_floor   03  02 fff00005 2 ffffffc7 0
sat_positive      ff  00 7f007fff 0 7fffffff 2
shift_no_sat      ff  08 7f007fff 1 3f7f4180 0
sat_negative      ff  00 80007fff 2 80000000 2
bad_k_zero        00  00 00000000 3 80000000 6
recover_valid     04  01 000a0002 0 0000002e 0
bad_k_large       12c 00 00000000 3 0000002e 4
clear_mid_job     40  00 00010001 4 00000000 0
after_clear       10  00 0002fffd 1 fffffe38 0
surplus_and_gaps  05  00 00640064 2 0000c738 0

// ==== test/tb_mac_top.sv ====
// Reads test/mac_tests.txt from the project root; pair i is x = x0 + i and w = w0, junk pairs are random
`default_nettype none

module tb_mac_top;

  timeunit 1ns;
  timeprecision 1ps;

  import mac_ctrl_pkg::*;
  import mac_data_pkg::*;

  localparam int access_limit = 8;
  localparam int busy_limit   = 10;
  localparam int idle_cycles  = 50;

  logic          clk_i;
  logic          rst_ni;
  periph_req_t   periph_req;
  periph_rsp_t   periph_rsp;
  operand_t      op;
  logic          op_valid;
  logic          busy;
  logic          evt;

  integer seed;
  integer errors;
  integer test_errors;
  integer tests_run;
  integer tests_failed;

  mac_top i_mac_top (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .periph_req_i ( periph_req ),
    .periph_rsp_o ( periph_rsp ),
    .op_i         ( op         ),
    .op_valid_i   ( op_valid   ),
    .busy_o       ( busy       ),
    .evt_o        ( evt        )
  );

  always #50 clk_i = ~clk_i;

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, sig, got, exp);
    errors = errors + 1;
    test_errors = test_errors + 1;
  endtask

  task automatic flag_problem(input string msg);
    $display("Problem at time %0t: %s", $time, msg);
    errors = errors + 1;
    test_errors = test_errors + 1;
  endtask

  // One access, started and finished on a falling edge
  task automatic reg_access(input logic wen, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int cnt;
    cnt = 0;
    rdata = '0;
    periph_req.req  = 1'b1;
    periph_req.wen  = wen;
    periph_req.add  = addr;
    periph_req.data = wdata;
    @(posedge clk_i);
    while (!periph_rsp.gnt && cnt < access_limit) begin
      @(posedge clk_i);
      cnt++;
    end
    if (!periph_rsp.gnt) begin
      flag_problem("register access was never granted");
    end
    @(negedge clk_i);
    periph_req = '0;
    cnt = 0;
    while (!periph_rsp.r_valid && cnt < access_limit) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!periph_rsp.r_valid) begin
      flag_problem("r_valid never followed a granted access");
    end else begin
      rdata = periph_rsp.r_data;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    reg_access(1'b1, addr, wdata, rdata);
    if (rdata !== 32'h0) begin
      report_mismatch("r_data on write", rdata, 32'h0);
    end
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
    reg_access(1'b0, addr, 32'h0, rdata);
  endtask

  task automatic drive_junk();
    logic [31:0] rnd;
    rnd = $random(seed);
    op = rnd;
    rnd = $random(seed);
    op_valid = rnd[0];
  endtask

  task automatic present_pair(input logic [31:0] op_word, input int idx);
    op.x = op_word[31:16] + idx[15:0];
    op.w = op_word[15:0];
    op_valid = 1'b1;
  endtask

  task automatic program_job(input logic [31:0] k, input logic [31:0] shift);
    write_reg(REG_K_LEN, k);
    write_reg(REG_SHIFT, shift);
    write_reg(REG_TRIGGER, 32'h1);
  endtask

  // Waits for busy, then lets the two STARTING cycles pass
  task automatic wait_busy_rise(input logic [31:0] mode, output logic ok);
    int cnt;
    cnt = 0;
    while (!busy && cnt < busy_limit) begin
      if (mode == 2) drive_junk();
      else op_valid = 1'b0;
      @(negedge clk_i);
      cnt++;
    end
    ok = busy;
    if (!busy) begin
      flag_problem("busy_o did not rise after a valid trigger");
    end
    repeat (2) begin
      if (mode == 2) drive_junk();
      else op_valid = 1'b0;
      @(negedge clk_i);
    end
  endtask

  task automatic check_readback(input logic [31:0] exp_result, input logic [31:0] exp_status);
    logic [31:0] rdata;
    read_reg(REG_RESULT, rdata);
    if (rdata !== exp_result) begin
      report_mismatch("RESULT", rdata, exp_result);
    end
    read_reg(REG_STATUS, rdata);
    if (rdata !== exp_status) begin
      report_mismatch("STATUS", rdata, exp_status);
    end
  endtask

  task automatic execute_job(input logic [31:0] k, input logic [31:0] shift,
                             input logic [31:0] op_word, input logic [31:0] mode,
                             input logic [31:0] exp_result, input logic [31:0] exp_status);
    int          idx;
    int          cnt;
    int          limit;
    logic        ok;
    logic [31:0] rnd;
    limit = 4 * k + 20;
    // Pairs ahead of the trigger must be dropped
    if (mode == 2) drive_junk();
    program_job(k, shift);
    wait_busy_rise(mode, ok);
    if (!ok) begin
      op_valid = 1'b0;
      return;
    end
    idx = 0;
    cnt = 0;
    while (idx < k && cnt < limit) begin
      rnd = $random(seed);
      if (mode != 0 && rnd[1:0] == 2'b00) begin
        op_valid = 1'b0;
      end else begin
        present_pair(op_word, idx);
        idx++;
      end
      @(negedge clk_i);
      cnt++;
      if (evt) begin
        flag_problem("evt_o pulsed before all pairs were driven");
      end
    end
    cnt = 0;
    while (!evt && cnt < limit) begin
      // Surplus pairs beyond K
      if (mode == 2) drive_junk();
      else op_valid = 1'b0;
      @(negedge clk_i);
      cnt++;
    end
    if (!evt) begin
      flag_problem("evt_o did not pulse at the end of the job");
      op_valid = 1'b0;
      return;
    end
    if (busy !== 1'b0) begin
      report_mismatch("busy_o", busy, 32'h0);
    end
    @(negedge clk_i);
    op_valid = 1'b0;
    if (evt !== 1'b0) begin
      report_mismatch("evt_o", evt, 32'h0);
    end
    check_readback(exp_result, exp_status);
  endtask

  task automatic reject_job(input logic [31:0] k, input logic [31:0] shift,
                            input logic [31:0] exp_result, input logic [31:0] exp_status);
    logic busy_seen;
    logic evt_seen;
    busy_seen = 1'b0;
    evt_seen = 1'b0;
    op_valid = 1'b0;
    program_job(k, shift);
    repeat (idle_cycles) begin
      @(negedge clk_i);
      busy_seen = busy_seen | busy;
      evt_seen = evt_seen | evt;
    end
    if (busy_seen !== 1'b0) begin
      report_mismatch("busy_o", busy_seen, 32'h0);
    end
    if (evt_seen !== 1'b0) begin
      report_mismatch("evt_o", evt_seen, 32'h0);
    end
    check_readback(exp_result, exp_status);
  endtask

  task automatic abort_job(input logic [31:0] k, input logic [31:0] shift,
                           input logic [31:0] op_word, input logic [31:0] exp_result,
                           input logic [31:0] exp_status);
    int   cnt;
    logic ok;
    logic evt_seen;
    evt_seen = 1'b0;
    program_job(k, shift);
    wait_busy_rise(32'h0, ok);
    if (!ok) begin
      return;
    end
    for (int i = 0; i < 3; i++) begin
      present_pair(op_word, i);
      @(negedge clk_i);
      evt_seen = evt_seen | evt;
    end
    op_valid = 1'b0;
    write_reg(REG_CLEAR, 32'h1);
    cnt = 0;
    while (busy && cnt < busy_limit) begin
      @(negedge clk_i);
      evt_seen = evt_seen | evt;
      cnt++;
    end
    if (busy !== 1'b0) begin
      report_mismatch("busy_o", busy, 32'h0);
    end
    repeat (20) begin
      @(negedge clk_i);
      evt_seen = evt_seen | evt;
    end
    if (evt_seen) begin
      flag_problem("evt_o pulsed although the job was cleared");
    end
    check_readback(exp_result, exp_status);
  endtask

  task automatic finish_test(input logic [8*32-1:0] name);
    tests_run = tests_run + 1;
    if (test_errors == 0) begin
      $display("PASS %0s", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("FAIL %0s with %0d failed checks", name, test_errors);
    end
  endtask

  initial begin
    #5_000_000;
    $display("Simulation watchdog expired before the tests completed");
    $display("Errors found");
    $finish;
  end

  initial begin
    integer           fd;
    integer           n;
    integer           fields;
    logic [8*160-1:0] line_buf;
    logic [8*32-1:0]  name;
    logic [31:0]      k;
    logic [31:0]      shift;
    logic [31:0]      op_word;
    logic [31:0]      mode;
    logic [31:0]      exp_result;
    logic [31:0]      exp_status;
    logic [31:0]      rdata;

    clk_i = 1'b0;
    rst_ni = 1'b0;
    periph_req = '0;
    op = '0;
    op_valid = 1'b0;
    seed = 32'h8905;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle state straight out of reset
    @(negedge clk_i);
    if (busy !== 1'b0) report_mismatch("busy_o", busy, 32'h0);
    if (evt !== 1'b0) report_mismatch("evt_o", evt, 32'h0);
    if (periph_rsp.gnt !== 1'b0) report_mismatch("gnt", periph_rsp.gnt, 32'h0);
    if (periph_rsp.r_valid !== 1'b0) report_mismatch("r_valid", periph_rsp.r_valid, 32'h0);
    read_reg(REG_STATUS, rdata);
    if (rdata !== 32'h0) report_mismatch("STATUS", rdata, 32'h0);
    finish_test("reset_state");

    fd = $fopen("test/mac_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the tests file test/mac_tests.txt");
      errors = errors + 1;
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        if (n > 0) begin
          fields = $sscanf(line_buf, "%s %h %h %h %h %h %h", name, k, shift, op_word, mode,
                           exp_result, exp_status);
          // Comment and blank lines do not yield all seven fields
          if (fields == 7) begin
            test_errors = 0;
            case (mode)
              0, 1, 2: execute_job(k, shift, op_word, mode, exp_result, exp_status);
              3:       reject_job(k, shift, exp_result, exp_status);
              4:       abort_job(k, shift, op_word, exp_result, exp_status);
              default: flag_problem("unknown gap mode in the tests file");
            endcase
            finish_test(name);
          end
        end
      end
      $fclose(fd);
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d, failed checks: %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+source
source/mac_ctrl_pkg.sv
source/mac_data_pkg.sv
source/mac_periph_decode.sv
source/mac_ctrl.sv
source/mac_engine.sv
source/mac_result.sv
source/mac_top.sv
test/tb_mac_top.sv
